// ==== rw_mgr_config.svh ====
// DDR2 read/write manager widths, host register map and AC table depth
`ifndef RW_MGR_CONFIG_SVH
`define RW_MGR_CONFIG_SVH

// host side
`define RW_AVL_DATA_WIDTH 32
`define RW_AVL_ADDR_WIDTH 16

// memory side, one rank and one chip select
`define RW_MEM_ADDR_WIDTH 13
`define RW_MEM_BANK_WIDTH 2
`define RW_MEM_DQ_WIDTH 8
`define RW_MEM_DM_WIDTH 1

// half rate, two phases per avl_clk
`define RW_AFI_RATIO 2

// AC word table and run counters
`define RW_TABLE_DEPTH 16
`define RW_LOOP_WIDTH 8
`define RW_BEAT_WIDTH 16

// register map, table entries sit at 0x00 to 0x0F
`define RW_ADDR_RUN 16'h0010
`define RW_ADDR_PATTERN 16'h0011
// writing status clears the error mask and the beat count
`define RW_ADDR_STATUS 16'h0012

`endif

// ==== rw_mgr_pkg.sv ====
// shared types for the DDR2 read/write manager: vectors, AC word, run request, FSM states
`default_nettype none

`include "rw_mgr_config.svh"

package rw_mgr_pkg;

	typedef logic [`RW_AVL_DATA_WIDTH-1:0] avl_data_t;
	// 8 DQ x 2 edges x 2 phases
	typedef logic [`RW_MEM_DQ_WIDTH*2*`RW_AFI_RATIO-1:0] afi_data_t;
	typedef logic [`RW_MEM_DQ_WIDTH-1:0] dq_mask_t;
	typedef logic [$clog2(`RW_TABLE_DEPTH)-1:0] tbl_index_t;
	typedef logic [`RW_LOOP_WIDTH-1:0] loop_count_t;
	typedef logic [`RW_BEAT_WIDTH-1:0] beat_count_t;

	// bits 25:0 follow the half-rate AC bus, bit 15 is an unused gap there
	typedef struct packed {
		logic cs;
		logic cke;
		logic odt;
		logic wdata_valid;
		logic rdata_en;
		logic rdata_en_full;
		logic dqs_burst_hi;
		logic dqs_burst_lo;
		logic we_n;
		logic cas_n;
		logic ras_n;
		logic rsvd;
		logic [`RW_MEM_BANK_WIDTH-1:0] bank;
		logic [`RW_MEM_ADDR_WIDTH-1:0] mem_addr;
	} ac_word_t;

	// deselect with all command strobes high, cke low
	localparam ac_word_t AC_IDLE_WORD = 27'h0070000;

	typedef struct packed {
		tbl_index_t start;
		tbl_index_t last_offset;
		loop_count_t loops;
	} run_req_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_FETCH,
		SEQ_PLAY,
		SEQ_DRAIN
	} seq_state_t;

endpackage

`default_nettype wire

// ==== rw_mgr_ac_table.sv ====
// AC word table with one host write port and registered sequencer and host read ports
`timescale 1ns/100ps
`default_nettype none

`include "rw_mgr_config.svh"

module rw_mgr_ac_table (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire logic wr_en,
	input wire rw_mgr_pkg::tbl_index_t wr_index,
	input wire rw_mgr_pkg::ac_word_t wr_word,
	input wire rw_mgr_pkg::tbl_index_t rd_index,
	output rw_mgr_pkg::ac_word_t rd_word,
	input wire rw_mgr_pkg::tbl_index_t host_index,
	output rw_mgr_pkg::ac_word_t host_word
);

	rw_mgr_pkg::ac_word_t mem [`RW_TABLE_DEPTH];

	// every entry starts as an idle word so an unloaded slice plays as NOPs
	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `RW_TABLE_DEPTH; i++) begin
				mem[i] <= rw_mgr_pkg::AC_IDLE_WORD;
			end
		end else if (wr_en) begin
			mem[wr_index] <= wr_word;
		end
	end

	// sequencer port, data follows the index by one cycle
	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			rd_word <= rw_mgr_pkg::AC_IDLE_WORD;
		end else begin
			rd_word <= mem[rd_index];
		end
	end

	// host readback port, ready in the second cycle of the access
	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			host_word <= rw_mgr_pkg::AC_IDLE_WORD;
		end else begin
			host_word <= mem[host_index];
		end
	end

endmodule

`default_nettype wire

// ==== rw_mgr_loop_counter.sv ====
// word offset and loop repeat counters for one run, flagging the final word
`timescale 1ns/100ps
`default_nettype none

module rw_mgr_loop_counter (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire logic load,
	input wire logic step,
	input wire rw_mgr_pkg::tbl_index_t last_offset,
	input wire rw_mgr_pkg::loop_count_t loops,
	output rw_mgr_pkg::tbl_index_t offset,
	output logic last_word
);

	rw_mgr_pkg::tbl_index_t last_offset_q;
	rw_mgr_pkg::loop_count_t loops_left;
	logic at_end;

	assign at_end = (offset == last_offset_q);

	// the slice has been played loops times once this word goes out
	assign last_word = at_end && (loops_left == rw_mgr_pkg::loop_count_t'(1));

	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			offset <= '0;
			loops_left <= '0;
			last_offset_q <= '0;
		end else if (load) begin
			offset <= '0;
			last_offset_q <= last_offset;
			// a loop count of zero still plays the slice once
			if (loops == '0) begin
				loops_left <= rw_mgr_pkg::loop_count_t'(1);
			end else begin
				loops_left <= loops;
			end
		end else if (step) begin
			if (at_end) begin
				offset <= '0;
				loops_left <= loops_left - rw_mgr_pkg::loop_count_t'(1);
			end else begin
				offset <= offset + rw_mgr_pkg::tbl_index_t'(1);
			end
		end
	end

endmodule

`default_nettype wire

// ==== rw_mgr_seq_fsm.sv ====
// run sequencer FSM: accepts a run, walks the table slice and reports busy
`timescale 1ns/100ps
`default_nettype none

module rw_mgr_seq_fsm (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire logic run_wr,
	input wire rw_mgr_pkg::run_req_t run_req,
	input wire logic last_word,
	input wire rw_mgr_pkg::tbl_index_t offset,
	output logic load,
	output logic step,
	output rw_mgr_pkg::tbl_index_t rd_index,
	output logic word_active,
	output logic busy
);

	rw_mgr_pkg::seq_state_t state;
	rw_mgr_pkg::seq_state_t state_nxt;
	rw_mgr_pkg::tbl_index_t start_q;
	logic fetch_valid;

	// a table index is presented in every FETCH and PLAY cycle
	assign fetch_valid = (state == rw_mgr_pkg::SEQ_FETCH) || (state == rw_mgr_pkg::SEQ_PLAY);

	assign load = (state == rw_mgr_pkg::SEQ_IDLE) && run_wr;
	assign step = fetch_valid;
	assign rd_index = start_q + offset;
	assign busy = (state != rw_mgr_pkg::SEQ_IDLE);

	always_comb begin
		state_nxt = state;
		case (state)
			rw_mgr_pkg::SEQ_IDLE: begin
				if (run_wr) begin
					state_nxt = rw_mgr_pkg::SEQ_FETCH;
				end
			end
			rw_mgr_pkg::SEQ_FETCH: begin
				// a one word run is already done after the first fetch
				if (last_word) begin
					state_nxt = rw_mgr_pkg::SEQ_DRAIN;
				end else begin
					state_nxt = rw_mgr_pkg::SEQ_PLAY;
				end
			end
			rw_mgr_pkg::SEQ_PLAY: begin
				if (last_word) begin
					state_nxt = rw_mgr_pkg::SEQ_DRAIN;
				end
			end
			rw_mgr_pkg::SEQ_DRAIN: begin
				// stay until the last word has been handed to the decode register
				if (!word_active) begin
					state_nxt = rw_mgr_pkg::SEQ_IDLE;
				end
			end
			default: begin
				state_nxt = rw_mgr_pkg::SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			state <= rw_mgr_pkg::SEQ_IDLE;
			word_active <= 1'b0;
		end else begin
			state <= state_nxt;
			// lines up with the table's registered read data
			word_active <= fetch_valid;
		end
	end

	always_ff @(posedge avl_clk) begin
		if (load) begin
			start_q <= run_req.start;
		end
	end

endmodule

`default_nettype wire

// ==== rw_mgr_ac_decode.sv ====
// registers the active AC word and spreads its fields over the half-rate AFI outputs
`timescale 1ns/100ps
`default_nettype none

`include "rw_mgr_config.svh"

module rw_mgr_ac_decode (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire rw_mgr_pkg::ac_word_t ac_word,
	input wire logic word_active,
	output logic [`RW_MEM_ADDR_WIDTH*`RW_AFI_RATIO-1:0] afi_addr,
	output logic [`RW_MEM_BANK_WIDTH*`RW_AFI_RATIO-1:0] afi_ba,
	output logic [`RW_AFI_RATIO-1:0] afi_cs_n,
	output logic [`RW_AFI_RATIO-1:0] afi_cke,
	output logic [`RW_AFI_RATIO-1:0] afi_odt,
	output logic [`RW_AFI_RATIO-1:0] afi_ras_n,
	output logic [`RW_AFI_RATIO-1:0] afi_cas_n,
	output logic [`RW_AFI_RATIO-1:0] afi_we_n,
	output logic [`RW_AFI_RATIO-1:0] afi_dqs_burst,
	output logic [`RW_AFI_RATIO-1:0] afi_wdata_valid,
	output logic [`RW_AFI_RATIO-1:0] afi_rdata_en,
	output logic [`RW_AFI_RATIO-1:0] afi_rdata_en_full
);

	rw_mgr_pkg::ac_word_t word_q;
	rw_mgr_pkg::ac_word_t idle_word;

	// between words the clock enable stays where the last word left it
	always_comb begin
		idle_word = rw_mgr_pkg::AC_IDLE_WORD;
		idle_word.cke = word_q.cke;
	end

	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			word_q <= rw_mgr_pkg::AC_IDLE_WORD;
		end else if (word_active) begin
			word_q <= ac_word;
		end else begin
			word_q <= idle_word;
		end
	end

	assign afi_addr = {`RW_AFI_RATIO{word_q.mem_addr}};
	assign afi_ba = {`RW_AFI_RATIO{word_q.bank}};
	assign afi_cs_n = {`RW_AFI_RATIO{~word_q.cs}};
	assign afi_cke = {`RW_AFI_RATIO{word_q.cke}};
	assign afi_odt = {`RW_AFI_RATIO{word_q.odt}};
	assign afi_ras_n = {`RW_AFI_RATIO{word_q.ras_n}};
	assign afi_cas_n = {`RW_AFI_RATIO{word_q.cas_n}};
	assign afi_we_n = {`RW_AFI_RATIO{word_q.we_n}};
	assign afi_wdata_valid = {`RW_AFI_RATIO{word_q.wdata_valid}};
	// the burst strobe is set per phase, low bit for phase 0
	assign afi_dqs_burst = {word_q.dqs_burst_hi, word_q.dqs_burst_lo};
	// read enables are issued on phase 0 only
	assign afi_rdata_en = {1'b0, word_q.rdata_en};
	assign afi_rdata_en_full = {1'b0, word_q.rdata_en_full};

endmodule

`default_nettype wire

// ==== rw_mgr_data_path.sv ====
// write pattern, read compare with sticky per-pin error mask, beat count and status word
`timescale 1ns/100ps
`default_nettype none

`include "rw_mgr_config.svh"

module rw_mgr_data_path (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire logic pattern_wr,
	input wire logic status_wr,
	input wire rw_mgr_pkg::avl_data_t wr_data,
	input wire logic busy,
	input wire logic wdata_valid,
	input wire rw_mgr_pkg::afi_data_t afi_rdata,
	input wire logic [`RW_AFI_RATIO-1:0] afi_rdata_valid,
	output rw_mgr_pkg::afi_data_t afi_wdata,
	output logic [`RW_MEM_DM_WIDTH*2*`RW_AFI_RATIO-1:0] afi_dm,
	output rw_mgr_pkg::avl_data_t pattern,
	output rw_mgr_pkg::avl_data_t status
);

	localparam int NUM_BYTES = $bits(rw_mgr_pkg::afi_data_t) / `RW_MEM_DQ_WIDTH;

	rw_mgr_pkg::afi_data_t rd_diff;
	rw_mgr_pkg::dq_mask_t rd_fold;
	rw_mgr_pkg::dq_mask_t err_mask;
	rw_mgr_pkg::beat_count_t beat_count;
	logic beat_seen;

	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			pattern <= '0;
		end else if (pattern_wr) begin
			pattern <= wr_data;
		end
	end

	// write data is only driven while the decoded word marks it valid
	assign afi_wdata = wdata_valid ? rw_mgr_pkg::afi_data_t'(pattern) : '0;
	assign afi_dm = '0;

	// every byte lane carries the same DQ pins, so fold lanes onto one mask
	always_comb begin
		rd_diff = afi_rdata ^ rw_mgr_pkg::afi_data_t'(pattern);
		rd_fold = '0;
		for (int i = 0; i < NUM_BYTES; i++) begin
			rd_fold = rd_fold | rd_diff[i*`RW_MEM_DQ_WIDTH +: `RW_MEM_DQ_WIDTH];
		end
	end

	assign beat_seen = |afi_rdata_valid;

	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			err_mask <= '0;
			beat_count <= '0;
		end else if (status_wr) begin
			err_mask <= '0;
			beat_count <= '0;
		end else if (beat_seen) begin
			err_mask <= err_mask | rd_fold;
			beat_count <= beat_count + rw_mgr_pkg::beat_count_t'(1);
		end
	end

	// beats in 31:16, failing pins in 15:8, busy in bit 0
	assign status = {beat_count, err_mask, 7'b0, busy};

endmodule

`default_nettype wire

// ==== rw_manager_ddr2.sv ====
// DDR2 calibration read/write manager top with Avalon host port and half-rate AFI port
`timescale 1ns/100ps
`default_nettype none

`include "rw_mgr_config.svh"

module rw_manager_ddr2 (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire logic [`RW_AVL_ADDR_WIDTH-1:0] avl_address,
	input wire logic avl_write,
	input wire rw_mgr_pkg::avl_data_t avl_writedata,
	input wire logic avl_read,
	output rw_mgr_pkg::avl_data_t avl_readdata,
	output logic avl_waitrequest,
	output logic [`RW_MEM_ADDR_WIDTH*`RW_AFI_RATIO-1:0] afi_addr,
	output logic [`RW_MEM_BANK_WIDTH*`RW_AFI_RATIO-1:0] afi_ba,
	output logic [`RW_AFI_RATIO-1:0] afi_cs_n,
	output logic [`RW_AFI_RATIO-1:0] afi_cke,
	output logic [`RW_AFI_RATIO-1:0] afi_odt,
	output logic [`RW_AFI_RATIO-1:0] afi_ras_n,
	output logic [`RW_AFI_RATIO-1:0] afi_cas_n,
	output logic [`RW_AFI_RATIO-1:0] afi_we_n,
	output logic [`RW_AFI_RATIO-1:0] afi_dqs_burst,
	output rw_mgr_pkg::afi_data_t afi_wdata,
	output logic [`RW_AFI_RATIO-1:0] afi_wdata_valid,
	output logic [`RW_MEM_DM_WIDTH*2*`RW_AFI_RATIO-1:0] afi_dm,
	output logic [`RW_AFI_RATIO-1:0] afi_rdata_en,
	output logic [`RW_AFI_RATIO-1:0] afi_rdata_en_full,
	input wire rw_mgr_pkg::afi_data_t afi_rdata,
	input wire logic [`RW_AFI_RATIO-1:0] afi_rdata_valid
);

	localparam int AC_BITS = $bits(rw_mgr_pkg::ac_word_t);

	logic phase_q, req, stall, accept;
	logic tbl_hit, table_wr, run_wr, pattern_wr, status_wr;
	logic busy, load, step, last_word, word_active;
	rw_mgr_pkg::run_req_t run_req;
	rw_mgr_pkg::tbl_index_t host_index, rd_index, offset;
	rw_mgr_pkg::ac_word_t rd_word, host_word;
	rw_mgr_pkg::avl_data_t pattern, status;

	assign req = avl_read || avl_write;
	assign tbl_hit = (avl_address < `RW_TABLE_DEPTH);

	// anything that changes what a run plays waits for the run to drain
	assign stall = avl_write && busy &&
		(tbl_hit || avl_address == `RW_ADDR_RUN || avl_address == `RW_ADDR_PATTERN);

	// first cycle of an access always waits, the second completes unless stalled
	always_ff @(posedge avl_clk) begin
		if (!rst_n) begin
			phase_q <= 1'b0;
		end else begin
			phase_q <= req && (!phase_q || stall);
		end
	end

	assign avl_waitrequest = !phase_q || stall;
	assign accept = req && phase_q && !stall;

	assign table_wr = accept && avl_write && tbl_hit;
	assign run_wr = accept && avl_write && (avl_address == `RW_ADDR_RUN);
	assign pattern_wr = accept && avl_write && (avl_address == `RW_ADDR_PATTERN);
	assign status_wr = accept && avl_write && (avl_address == `RW_ADDR_STATUS);

	assign host_index = avl_address[$bits(rw_mgr_pkg::tbl_index_t)-1:0];
	assign run_req.start = avl_writedata[3:0];
	assign run_req.last_offset = avl_writedata[7:4];
	assign run_req.loops = avl_writedata[15:8];

	// RUN and unmapped addresses read back as zero
	always_comb begin
		avl_readdata = '0;
		if (tbl_hit) begin
			avl_readdata = {{(`RW_AVL_DATA_WIDTH-AC_BITS){1'b0}}, host_word};
		end else if (avl_address == `RW_ADDR_PATTERN) begin
			avl_readdata = pattern;
		end else if (avl_address == `RW_ADDR_STATUS) begin
			avl_readdata = status;
		end
	end

	rw_mgr_ac_table u_ac_table (
		.avl_clk(avl_clk), .rst_n(rst_n), .wr_en(table_wr), .wr_index(host_index),
		.wr_word(rw_mgr_pkg::ac_word_t'(avl_writedata[AC_BITS-1:0])),
		.rd_index(rd_index), .rd_word(rd_word), .host_index(host_index), .host_word(host_word)
	);

	rw_mgr_loop_counter u_loop_counter (
		.avl_clk(avl_clk), .rst_n(rst_n), .load(load), .step(step),
		.last_offset(run_req.last_offset), .loops(run_req.loops),
		.offset(offset), .last_word(last_word)
	);

	rw_mgr_seq_fsm u_seq_fsm (
		.avl_clk(avl_clk), .rst_n(rst_n), .run_wr(run_wr), .run_req(run_req),
		.last_word(last_word), .offset(offset), .load(load), .step(step),
		.rd_index(rd_index), .word_active(word_active), .busy(busy)
	);

	rw_mgr_ac_decode u_ac_decode (
		.avl_clk(avl_clk), .rst_n(rst_n), .ac_word(rd_word), .word_active(word_active),
		.afi_addr(afi_addr), .afi_ba(afi_ba), .afi_cs_n(afi_cs_n), .afi_cke(afi_cke),
		.afi_odt(afi_odt), .afi_ras_n(afi_ras_n), .afi_cas_n(afi_cas_n), .afi_we_n(afi_we_n),
		.afi_dqs_burst(afi_dqs_burst), .afi_wdata_valid(afi_wdata_valid),
		.afi_rdata_en(afi_rdata_en), .afi_rdata_en_full(afi_rdata_en_full)
	);

	rw_mgr_data_path u_data_path (
		.avl_clk(avl_clk), .rst_n(rst_n), .pattern_wr(pattern_wr), .status_wr(status_wr),
		.wr_data(avl_writedata), .busy(busy), .wdata_valid(afi_wdata_valid[0]),
		.afi_rdata(afi_rdata), .afi_rdata_valid(afi_rdata_valid), .afi_wdata(afi_wdata),
		.afi_dm(afi_dm), .pattern(pattern), .status(status)
	);

endmodule

`default_nettype wire

// ==== rw_mgr_checker.sv ====
// checker for the DDR2 read/write manager: mirrors host writes and compares every AFI cycle
`timescale 1ns/100ps
`default_nettype none

`include "rw_mgr_config.svh"

module rw_mgr_checker (
	input wire logic avl_clk,
	input wire logic rst_n,
	input wire logic [15:0] avl_address,
	input wire logic avl_write,
	input wire logic [31:0] avl_writedata,
	input wire logic avl_waitrequest,
	input wire logic [25:0] afi_addr,
	input wire logic [3:0] afi_ba,
	input wire logic [1:0] afi_cs_n,
	input wire logic [1:0] afi_cke,
	input wire logic [1:0] afi_odt,
	input wire logic [1:0] afi_ras_n,
	input wire logic [1:0] afi_cas_n,
	input wire logic [1:0] afi_we_n,
	input wire logic [1:0] afi_dqs_burst,
	input wire logic [31:0] afi_wdata,
	input wire logic [3:0] afi_dm,
	input wire logic [1:0] afi_wdata_valid,
	input wire logic [1:0] afi_rdata_en,
	input wire logic [1:0] afi_rdata_en_full,
	input wire logic rpt,
	input wire logic [127:0] rpt_name,
	input wire logic [15:0] exp_act,
	input wire logic [15:0] exp_wr,
	input wire logic [15:0] exp_rd,
	input wire logic [7:0] exp_mask,
	input wire logic [15:0] exp_beats,
	input wire logic [31:0] rpt_status,
	output int pass_count,
	output int fail_count
);

	rw_mgr_pkg::ac_word_t mirror [16];
	rw_mgr_pkg::ac_word_t exp_q [$];
	rw_mgr_pkg::ac_word_t w, obs, idle;
	logic [31:0] pattern_q, err_exp, err_act;
	logic exp_cke, row_err;
	logic [23:0] ph0, ph1;
	int edge_n, start_edge, n_act, n_wr, n_rd, loops;
	logic [3:0] start, last;

	task automatic note_error(input logic [31:0] exp, input logic [31:0] act);
		if (!row_err) begin
			row_err = 1'b1;
			err_exp = exp;
			err_act = act;
		end
	endtask

	task automatic report_row();
		if (row_err) begin
			$display("Fail %0s AFI cycle expected %h actual %h", rpt_name, err_exp, err_act);
		end else if (exp_act != 16'(n_act)) begin
			$display("Fail %0s activates expected %0d actual %0d", rpt_name, exp_act, n_act);
		end else if (exp_wr != 16'(n_wr)) begin
			$display("Fail %0s writes expected %0d actual %0d", rpt_name, exp_wr, n_wr);
		end else if (exp_rd != 16'(n_rd)) begin
			$display("Fail %0s reads expected %0d actual %0d", rpt_name, exp_rd, n_rd);
		end else if (exp_mask != rpt_status[15:8]) begin
			$display("Fail %0s error mask expected %h actual %h", rpt_name, exp_mask,
				rpt_status[15:8]);
		end else if (exp_beats != rpt_status[31:16]) begin
			$display("Fail %0s beats expected %0d actual %0d", rpt_name, exp_beats,
				rpt_status[31:16]);
		end else if (rpt_status[0]) begin
			$display("Fail %0s busy expected 0 actual 1", rpt_name);
		end else begin
			$display("Pass %0s", rpt_name);
			pass_count++;
			row_err = 1'b0;
			return;
		end
		fail_count++;
		row_err = 1'b0;
	endtask

	always @(posedge avl_clk) begin
		if (!rst_n) begin
			idle = '0;
			idle.ras_n = 1'b1;
			idle.cas_n = 1'b1;
			idle.we_n = 1'b1;
			for (int i = 0; i < 16; i++) begin
				mirror[i] = idle;
			end
			exp_q.delete();
			pattern_q = '0;
			exp_cke = 1'b0;
			row_err = 1'b0;
			edge_n = 0;
			start_edge = 0;
			n_act = 0;
			n_wr = 0;
			n_rd = 0;
			pass_count = 0;
			fail_count = 0;
		end else begin
			edge_n++;
			obs = '0;
			obs.mem_addr = afi_addr[12:0];
			obs.bank = afi_ba[1:0];
			obs.cs = ~afi_cs_n[0];
			obs.cke = afi_cke[0];
			obs.odt = afi_odt[0];
			obs.ras_n = afi_ras_n[0];
			obs.cas_n = afi_cas_n[0];
			obs.we_n = afi_we_n[0];
			obs.dqs_burst_lo = afi_dqs_burst[0];
			obs.dqs_burst_hi = afi_dqs_burst[1];
			obs.wdata_valid = afi_wdata_valid[0];
			obs.rdata_en = afi_rdata_en[0];
			obs.rdata_en_full = afi_rdata_en_full[0];
			// phase 1 repeats phase 0, read enables stay low on phase 1
			ph0 = {afi_addr[12:0], afi_ba[1:0], afi_cs_n[0], afi_cke[0], afi_odt[0],
				afi_ras_n[0], afi_cas_n[0], afi_we_n[0], afi_wdata_valid[0], 2'b00};
			ph1 = {afi_addr[25:13], afi_ba[3:2], afi_cs_n[1], afi_cke[1], afi_odt[1],
				afi_ras_n[1], afi_cas_n[1], afi_we_n[1], afi_wdata_valid[1],
				afi_rdata_en[1], afi_rdata_en_full[1]};
			if (ph1 !== ph0) begin
				note_error(32'(ph0), 32'(ph1));
			end
			if (afi_dm !== 4'h0) begin
				note_error(32'h0, 32'(afi_dm));
			end
			if (exp_q.size() > 0 && edge_n >= start_edge) begin
				w = exp_q.pop_front();
				w.rsvd = 1'b0;
				exp_cke = w.cke;
				if (obs !== w) begin
					note_error(32'(w), 32'(obs));
				end
			end else begin
				// address and bank carry no meaning between words
				w = idle;
				w.cke = exp_cke;
				obs.mem_addr = '0;
				obs.bank = '0;
				if (obs !== w) begin
					note_error(32'(w), 32'(obs));
				end
			end
			if (afi_wdata_valid[0] && afi_wdata !== pattern_q) begin
				note_error(pattern_q, afi_wdata);
			end else if (!afi_wdata_valid[0] && afi_wdata !== 32'h0) begin
				note_error(32'h0, afi_wdata);
			end
			if (!afi_cs_n[0]) begin
				if (!afi_ras_n[0] && afi_cas_n[0]) begin
					n_act++;
				end else if (afi_ras_n[0] && !afi_cas_n[0] && !afi_we_n[0]) begin
					n_wr++;
				end else if (afi_ras_n[0] && !afi_cas_n[0] && afi_we_n[0]) begin
					n_rd++;
				end
			end
			if (avl_write && !avl_waitrequest) begin
				if (avl_address < 16'd16) begin
					mirror[avl_address[3:0]] = rw_mgr_pkg::ac_word_t'(avl_writedata[26:0]);
				end else if (avl_address == `RW_ADDR_PATTERN) begin
					pattern_q = avl_writedata;
				end else if (avl_address == `RW_ADDR_RUN) begin
					start = avl_writedata[3:0];
					last = avl_writedata[7:4];
					loops = (avl_writedata[15:8] == 8'd0) ? 1 : int'(avl_writedata[15:8]);
					for (int l = 0; l < loops; l++) begin
						for (int o = 0; o <= int'(last); o++) begin
							exp_q.push_back(mirror[4'(int'(start) + o)]);
						end
					end
					// first word leaves the decode register three cycles after acceptance
					start_edge = edge_n + 3;
					n_act = 0;
					n_wr = 0;
					n_rd = 0;
				end
			end
			if (rpt) begin
				report_row();
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_rw_manager_ddr2.sv ====
// testbench for the DDR2 read/write manager: host stimulus table, read loopback model, watchdog
`timescale 1ns/100ps
`default_nettype none

`include "rw_mgr_config.svh"

module tb_rw_manager_ddr2;

	localparam int NUM_ROWS = 4;
	localparam int LIMIT_CYCLES = (NUM_ROWS + 2) * (16 * 255 + 100);
	localparam logic [2:0] CMD_ACT = 3'b011;
	localparam logic [2:0] CMD_WR = 3'b100;
	localparam logic [2:0] CMD_RD = 3'b101;
	localparam logic [2:0] CMD_NOP = 3'b111;

	logic avl_clk = 1'b0;
	logic rst_n;
	logic [15:0] avl_address;
	logic avl_write, avl_read, avl_waitrequest;
	logic [31:0] avl_writedata, avl_readdata;
	logic [25:0] afi_addr;
	logic [3:0] afi_ba, afi_dm;
	logic [1:0] afi_cs_n, afi_cke, afi_odt, afi_ras_n, afi_cas_n, afi_we_n;
	logic [1:0] afi_dqs_burst, afi_wdata_valid, afi_rdata_en, afi_rdata_en_full;
	logic [1:0] afi_rdata_valid;
	logic [31:0] afi_wdata, afi_rdata;

	// report strobe towards the checker
	logic rpt;
	logic [127:0] rpt_name;
	logic [15:0] rpt_act, rpt_wr, rpt_rd;
	logic [7:0] rpt_mask;
	logic [15:0] rpt_beats;
	logic [31:0] rpt_status;
	int chk_pass, chk_fail;
	int tb_pass = 0;
	int tb_fail = 0;

	// stimulus table, one run per row
	logic [127:0] row_name [NUM_ROWS];
	logic [3:0] row_start [NUM_ROWS];
	logic [3:0] row_last [NUM_ROWS];
	logic [7:0] row_loops [NUM_ROWS];
	logic [31:0] row_pattern [NUM_ROWS];
	logic [31:0] row_corrupt [NUM_ROWS];
	logic [7:0] row_act [NUM_ROWS];
	logic [7:0] row_wr [NUM_ROWS];
	logic [7:0] row_rd [NUM_ROWS];
	logic [7:0] row_mask [NUM_ROWS];
	logic [15:0] row_beats [NUM_ROWS];

	// memory model state
	integer seed = 32'hc2bb;
	int cyc = 0;
	int lat, due;
	int due_q [$];
	logic [31:0] cur_pattern = '0;
	logic [31:0] cur_corrupt = '0;
	rw_mgr_pkg::ac_word_t words [8];

	always #2 avl_clk = ~avl_clk;

	rw_manager_ddr2 u_rw_manager_ddr2 (
		.avl_clk(avl_clk), .rst_n(rst_n), .avl_address(avl_address), .avl_write(avl_write),
		.avl_writedata(avl_writedata), .avl_read(avl_read), .avl_readdata(avl_readdata),
		.avl_waitrequest(avl_waitrequest), .afi_addr(afi_addr), .afi_ba(afi_ba),
		.afi_cs_n(afi_cs_n), .afi_cke(afi_cke), .afi_odt(afi_odt), .afi_ras_n(afi_ras_n),
		.afi_cas_n(afi_cas_n), .afi_we_n(afi_we_n), .afi_dqs_burst(afi_dqs_burst),
		.afi_wdata(afi_wdata), .afi_wdata_valid(afi_wdata_valid), .afi_dm(afi_dm),
		.afi_rdata_en(afi_rdata_en), .afi_rdata_en_full(afi_rdata_en_full),
		.afi_rdata(afi_rdata), .afi_rdata_valid(afi_rdata_valid)
	);

	rw_mgr_checker u_checker (
		.avl_clk(avl_clk), .rst_n(rst_n), .avl_address(avl_address), .avl_write(avl_write),
		.avl_writedata(avl_writedata), .avl_waitrequest(avl_waitrequest),
		.afi_addr(afi_addr), .afi_ba(afi_ba), .afi_cs_n(afi_cs_n), .afi_cke(afi_cke),
		.afi_odt(afi_odt), .afi_ras_n(afi_ras_n), .afi_cas_n(afi_cas_n), .afi_we_n(afi_we_n),
		.afi_dqs_burst(afi_dqs_burst), .afi_wdata(afi_wdata), .afi_dm(afi_dm),
		.afi_wdata_valid(afi_wdata_valid), .afi_rdata_en(afi_rdata_en),
		.afi_rdata_en_full(afi_rdata_en_full), .rpt(rpt), .rpt_name(rpt_name),
		.exp_act(rpt_act), .exp_wr(rpt_wr), .exp_rd(rpt_rd), .exp_mask(rpt_mask),
		.exp_beats(rpt_beats), .rpt_status(rpt_status),
		.pass_count(chk_pass), .fail_count(chk_fail)
	);

	// read loopback, each rdata_en returns one beat 2 to 5 cycles later, in order
	always @(posedge avl_clk) begin
		if (!rst_n) begin
			afi_rdata_valid <= 2'b00;
			afi_rdata <= '0;
		end else begin
			if (afi_rdata_en[0]) begin
				lat = 2 + int'($unsigned($random(seed)) % 4);
				due = cyc + lat;
				if (due_q.size() > 0 && due <= due_q[$]) begin
					due = due_q[$] + 1;
				end
				due_q.push_back(due);
			end
			if (due_q.size() > 0 && due_q[0] == cyc) begin
				void'(due_q.pop_front());
				afi_rdata_valid <= 2'b01;
				afi_rdata <= cur_pattern ^ cur_corrupt;
			end else begin
				afi_rdata_valid <= 2'b00;
				afi_rdata <= '0;
			end
		end
		cyc = cyc + 1;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge avl_clk);
		$display("watchdog expired before all tests finished");
		$display(">>> FAIL");
		$finish;
	end

	function automatic rw_mgr_pkg::ac_word_t make_word(input logic [2:0] rcw,
			input logic [1:0] bank, input logic [12:0] addr, input logic wr_dat,
			input logic rd_en);
		rw_mgr_pkg::ac_word_t w;
		w = '0;
		w.cs = 1'b1;
		w.cke = 1'b1;
		w.ras_n = rcw[2];
		w.cas_n = rcw[1];
		w.we_n = rcw[0];
		w.bank = bank;
		w.mem_addr = addr;
		w.wdata_valid = wr_dat;
		w.dqs_burst_lo = wr_dat;
		w.dqs_burst_hi = wr_dat;
		w.odt = wr_dat;
		w.rdata_en = rd_en;
		w.rdata_en_full = rd_en;
		return w;
	endfunction

	task automatic set_row(input int i, input logic [127:0] name, input logic [3:0] start,
			input logic [3:0] last, input logic [7:0] loops, input logic [31:0] pat,
			input logic [31:0] corrupt, input logic [7:0] act, input logic [7:0] wr,
			input logic [7:0] rd, input logic [7:0] mask, input logic [15:0] beats);
		row_name[i] = name;
		row_start[i] = start;
		row_last[i] = last;
		row_loops[i] = loops;
		row_pattern[i] = pat;
		row_corrupt[i] = corrupt;
		row_act[i] = act;
		row_wr[i] = wr;
		row_rd[i] = rd;
		row_mask[i] = mask;
		row_beats[i] = beats;
	endtask

	// the access completes on the edge after waitrequest is seen low
	task automatic wait_accept();
		do begin
			@(negedge avl_clk);
		end while (avl_waitrequest);
	endtask

	task automatic host_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge avl_clk);
		avl_address <= addr;
		avl_writedata <= data;
		avl_write <= 1'b1;
		wait_accept();
		@(posedge avl_clk);
		avl_write <= 1'b0;
	endtask

	task automatic host_read(input logic [15:0] addr, output logic [31:0] data);
		@(posedge avl_clk);
		avl_address <= addr;
		avl_read <= 1'b1;
		wait_accept();
		data = avl_readdata;
		@(posedge avl_clk);
		avl_read <= 1'b0;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("Fail %s expected %h actual %h", name, exp, act);
			tb_fail++;
		end else begin
			$display("Pass %s", name);
			tb_pass++;
		end
	endtask

	task automatic send_report(input logic [127:0] name, input logic [15:0] act,
			input logic [15:0] wr, input logic [15:0] rd, input logic [7:0] mask,
			input logic [15:0] beats, input logic [31:0] status);
		@(posedge avl_clk);
		rpt <= 1'b1;
		rpt_name <= name;
		rpt_act <= act;
		rpt_wr <= wr;
		rpt_rd <= rd;
		rpt_mask <= mask;
		rpt_beats <= beats;
		rpt_status <= status;
		@(posedge avl_clk);
		rpt <= 1'b0;
	endtask

	task automatic wait_beats(input logic [15:0] beats, output logic [31:0] st);
		do begin
			host_read(`RW_ADDR_STATUS, st);
		end while (st[0] || st[31:16] < beats);
		host_read(`RW_ADDR_STATUS, st);
	endtask

	initial begin
		logic [31:0] st;
		logic [31:0] rb;
		logic [31:0] bad_exp;
		logic [31:0] bad_act;
		int total_fail;
		rst_n = 1'b0;
		avl_address = '0;
		avl_write = 1'b0;
		avl_writedata = '0;
		avl_read = 1'b0;
		rpt = 1'b0;
		rpt_name = '0;
		rpt_act = '0;
		rpt_wr = '0;
		rpt_rd = '0;
		rpt_mask = '0;
		rpt_beats = '0;
		rpt_status = '0;
		words[0] = make_word(CMD_ACT, 2'd1, 13'h0100, 1'b0, 1'b0);
		words[1] = make_word(CMD_WR, 2'd1, 13'h0010, 1'b1, 1'b0);
		words[2] = make_word(CMD_RD, 2'd1, 13'h0010, 1'b0, 1'b1);
		words[3] = make_word(CMD_NOP, 2'd0, 13'h0003, 1'b0, 1'b0);
		words[4] = make_word(CMD_RD, 2'd1, 13'h0020, 1'b0, 1'b1);
		words[5] = make_word(CMD_WR, 2'd1, 13'h0020, 1'b1, 1'b0);
		words[6] = make_word(CMD_NOP, 2'd3, 13'h0066, 1'b0, 1'b0);
		words[7] = make_word(CMD_ACT, 2'd2, 13'h1f00, 1'b0, 1'b0);
		// a burst on phase 0 only and a read without the full enable keep paired fields apart
		words[1].dqs_burst_hi = 1'b0;
		words[2].rdata_en_full = 1'b0;
		// name, start, last, loops, pattern, corrupt, act, wr, rd, mask, beats
		set_row(0, "clean_all", 4'd0, 4'd7, 8'd1, 32'ha5a55a5a, 32'h0, 8'd2, 8'd2, 8'd2,
			8'h00, 16'd2);
		set_row(1, "loop_rd", 4'd1, 4'd3, 8'd3, 32'h12345678, 32'h00000101, 8'd0, 8'd3,
			8'd6, 8'h01, 16'd6);
		set_row(2, "single", 4'd2, 4'd0, 8'd0, 32'hffff0000, 32'h80400000, 8'd0, 8'd0,
			8'd1, 8'hc0, 16'd1);
		set_row(3, "wrap_pins", 4'd4, 4'd3, 8'd2, 32'h0f0f3c3c, 32'h0f00f000, 8'd2, 8'd2,
			8'd2, 8'hff, 16'd2);
		repeat (2) @(posedge avl_clk);
		rst_n <= 1'b1;

		for (int i = 0; i < 8; i++) begin
			host_write(16'(i), 32'(words[i]));
		end
		bad_exp = '0;
		bad_act = '0;
		for (int i = 0; i < 8; i++) begin
			host_read(16'(i), rb);
			if (rb !== 32'(words[i]) && bad_exp == bad_act) begin
				bad_exp = 32'(words[i]);
				bad_act = rb;
			end
		end
		check_value("table_rb", bad_exp, bad_act);

		for (int i = 0; i < NUM_ROWS; i++) begin
			cur_pattern = row_pattern[i];
			cur_corrupt = row_corrupt[i];
			host_write(`RW_ADDR_STATUS, 32'h0);
			host_write(`RW_ADDR_PATTERN, row_pattern[i]);
			host_write(`RW_ADDR_RUN, {16'h0, row_loops[i], row_last[i], row_start[i]});
			wait_beats(row_beats[i], st);
			send_report(row_name[i], 16'(row_act[i]), 16'(row_wr[i]), 16'(row_rd[i]),
				row_mask[i], row_beats[i], st);
		end

		// a long run with a table write that must wait for the drain
		cur_corrupt = '0;
		host_write(`RW_ADDR_STATUS, 32'h0);
		host_write(`RW_ADDR_RUN, {16'h0, 8'd200, 4'd3, 4'd1});
		host_read(`RW_ADDR_STATUS, st);
		check_value("busy_read", 32'h1, {31'h0, st[0]});
		host_write(16'h0003, 32'(make_word(CMD_NOP, 2'd0, 13'h1abc, 1'b0, 1'b0)));
		host_read(`RW_ADDR_STATUS, st);
		check_value("stall_write", 32'h0, {31'h0, st[0]});
		wait_beats(16'd400, st);
		send_report("stall_run", 16'd0, 16'd200, 16'd400, 8'h00, 16'd400, st);

		// a write-only run keeps the old pattern until the new one is accepted after the drain
		host_write(`RW_ADDR_STATUS, 32'h0);
		host_write(`RW_ADDR_RUN, {16'h0, 8'd100, 4'd1, 4'd5});
		host_write(`RW_ADDR_PATTERN, 32'h3c3cc3c3);
		host_read(`RW_ADDR_STATUS, st);
		check_value("stall_pattern", 32'h0, {31'h0, st[0]});
		wait_beats(16'd0, st);
		send_report("pattern_run", 16'd0, 16'd100, 16'd0, 8'h00, 16'd0, st);

		repeat (2) @(posedge avl_clk);
		total_fail = tb_fail + chk_fail;
		$display("tests passed %0d failed %0d", tb_pass + chk_pass, total_fail);
		if (total_fail == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
rw_mgr_pkg.sv
rw_mgr_ac_table.sv
rw_mgr_loop_counter.sv
rw_mgr_seq_fsm.sv
rw_mgr_ac_decode.sv
rw_mgr_data_path.sv
rw_manager_ddr2.sv
rw_mgr_checker.sv
tb_rw_manager_ddr2.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_rw_manager_ddr2 \
	-f files.f -o sim_rw_manager_ddr2 &&
./obj_dir/sim_rw_manager_ddr2 | tee /dev/stderr | grep -q ">>> PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
